//--- Bender.yml
package:
  name: obj_line_engine

sources:
  - verilog/obj_pkg.sv
  - verilog/obj_write_if.sv
  - verilog/obj_row_buffer.sv
  - verilog/obj_row_double_buffer.sv
  - verilog/obj_line_renderer.sv
  - verilog/obj_line_engine.sv
  - target: test
    files:
      - test/obj_line_engine_sva.sv
      - test/tb_obj_line_engine.sv

//--- filelist.f
verilog/obj_pkg.sv
verilog/obj_write_if.sv
verilog/obj_row_buffer.sv
verilog/obj_row_double_buffer.sv
verilog/obj_line_renderer.sv
verilog/obj_line_engine.sv
test/obj_line_engine_sva.sv
test/tb_obj_line_engine.sv

//--- test/obj_line_engine_sva.sv
module obj_line_engine_sva (
    input logic                         clock,
    input logic                         rst_n,
    input logic                         start,
    input logic                         busy,
    input logic                         we,
    input logic [obj_pkg::COL_BITS-1:0] wcol,
    input logic                         wr_clear
);
    import obj_pkg::*;

    // An accepted start holds busy for one cycle per sprite pixel
    property busy_length;
        @(posedge clock) disable iff (!rst_n)
            (start && !busy) |=> busy [*SPRITE_PIXELS] ##1 !busy;
    endproperty

    property write_in_line;
        @(posedge clock) disable iff (!rst_n)
            we |-> (wcol < COL_BITS'(LINE_WIDTH));
    endproperty

    property clear_excludes_write;
        @(posedge clock) disable iff (!rst_n)
            !(wr_clear && we);
    endproperty

    a_busy_length: assert property (busy_length)
        else $error("busy did not stay high for %0d cycles", SPRITE_PIXELS);

    a_write_in_line: assert property (write_in_line)
        else $error("write strobe with column %0d outside the line", wcol);

    a_clear_excludes_write: assert property (clear_excludes_write)
        else $error("clear and write strobe high in the same cycle");

endmodule : obj_line_engine_sva

bind obj_line_engine obj_line_engine_sva sva_checks (
    .clock    (clock),
    .rst_n    (rst_n),
    .start    (start),
    .busy     (busy),
    .we       (wr_bus.we),
    .wcol     (wr_bus.wcol),
    .wr_clear (wr_bus.clear)
);

//--- test/tb_obj_line_engine.sv
module tb_obj_line_engine;
    import obj_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          DRIVE_DLY    = 5;
    localparam logic [31:0] SEED         = 32'h823d3005;
    localparam int          NUM_COMMANDS = 19;
    localparam int          NUM_SWEEPS   = 15;
    localparam int          SWEEP_CYCLES = 257;
    localparam int          CMD_CYCLES   = 11;
    // Reset, row changes and clears fit easily in the margin
    localparam int MAX_CYCLES = NUM_SWEEPS * SWEEP_CYCLES + NUM_COMMANDS * CMD_CYCLES + 400;

    logic                 clock;
    logic                 rst_n;
    logic                 start;
    logic [COL_BITS-1:0]  x;
    logic [ATTR_BITS-1:0] attr;
    logic                 hflip;
    obj_row_t             pixels;
    logic                 palettemode;
    logic                 clear;
    logic [COL_BITS-1:0]  row;
    logic [COL_BITS-1:0]  rcol;
    logic                 busy;
    obj_pixel_t           rdata;

    // Model of both halves, indexed by row parity
    obj_pixel_t ref_buf [2][LINE_WIDTH];

    string cur_test;
    int    errors;
    int    checks;
    int    tests_done;
    int    test_errors;
    int    cycle_count;
    logic  sweep_go;

    obj_line_engine uut (
        .clock       (clock),
        .rst_n       (rst_n),
        .start       (start),
        .x           (x),
        .attr        (attr),
        .hflip       (hflip),
        .pixels      (pixels),
        .palettemode (palettemode),
        .clear       (clear),
        .row         (row),
        .rcol        (rcol),
        .busy        (busy),
        .rdata       (rdata)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin : watchdog
        wait (cycle_count >= MAX_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ########################################################################
    // Reference model
    // ########################################################################

    function automatic logic ref_transparent(input obj_pixel_t p, input logic pal);
        logic result;
        if (pal) begin
            result = (p.color[7:0] == 8'd0);
        end else begin
            result = (p.color == 16'd0);
        end
        return result;
    endfunction

    function automatic void apply_command(input logic [COL_BITS-1:0] cx,
                                          input logic [ATTR_BITS-1:0] cattr,
                                          input logic cflip, input obj_row_t cpix);
        int         side;
        int         col;
        int         i;
        obj_pixel_t pix;
        side = int'(row[0]);
        for (i = 0; i < SPRITE_PIXELS; i++) begin
            col = int'(cx) + i;
            pix.prio   = cattr[3:2];
            pix.semi   = cattr[1];
            pix.window = cattr[0];
            pix.color  = cflip ? cpix[SPRITE_PIXELS - 1 - i] : cpix[i];
            // First opaque pixel in a column keeps it
            if (col < LINE_WIDTH && ref_transparent(ref_buf[side][col], palettemode)) begin
                ref_buf[side][col] = pix;
            end
        end
    endfunction

    function automatic obj_pixel_t expected_read(input int col);
        obj_pixel_t result;
        result = '0;
        if (col < LINE_WIDTH) begin
            result = ref_buf[int'(!row[0])][col];
        end
        return result;
    endfunction

    function automatic obj_row_t random_row();
        obj_row_t    r;
        logic [31:0] v;
        for (int i = 0; i < SPRITE_PIXELS; i++) begin
            v = $urandom;
            if (v[7:0] == 8'd0) begin
                v[7:0] = 8'h5a;
            end
            r[i] = v[15:0];
        end
        return r;
    endfunction

    // Opaque only in direct-colour mode
    function automatic obj_row_t high_byte_row();
        obj_row_t r;
        for (int i = 0; i < SPRITE_PIXELS; i++) begin
            r[i] = {8'($urandom) | 8'h01, 8'h00};
        end
        return r;
    endfunction

    // ########################################################################
    // Compare tasks
    // ########################################################################

    task automatic check_pixel(input string name, input obj_pixel_t exp, input obj_pixel_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_busy(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected busy %b, actual %b", name, exp, act);
        end
    endtask

    // The sweep side owns rcol and compares every column against the model
    initial begin : sweep_checker
        obj_pixel_t exp;
        int         c;
        forever begin
            wait (sweep_go);
            for (c = 0; c < 256; c++) begin
                @(posedge clock);
                #DRIVE_DLY rcol = COL_BITS'(c);
                @(negedge clock);
                exp = expected_read(c);
                check_pixel($sformatf("%s col %0d", cur_test, c), exp, rdata);
            end
            sweep_go = 1'b0;
        end
    end

    // ########################################################################
    // Stimulus tasks
    // ########################################################################

    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DLY;
    endtask

    task automatic set_row(input int r);
        next_cycle();
        row = COL_BITS'(r);
    endtask

    task automatic set_mode(input logic pal);
        next_cycle();
        palettemode = pal;
    endtask

    task automatic sweep_line();
        sweep_go = 1'b1;
        wait (!sweep_go);
    endtask

    task automatic clear_line();
        next_cycle();
        clear = 1'b1;
        for (int i = 0; i < LINE_WIDTH; i++) begin
            ref_buf[int'(row[0])][i] = '0;
        end
        next_cycle();
        clear = 1'b0;
    endtask

    task automatic drive_start(input logic [COL_BITS-1:0] cx, input logic [ATTR_BITS-1:0] cattr,
                               input logic cflip, input obj_row_t cpix);
        next_cycle();
        x      = cx;
        attr   = cattr;
        hflip  = cflip;
        pixels = cpix;
        start  = 1'b1;
        next_cycle();
        start  = 1'b0;
    endtask

    task automatic expect_busy_run(input string name, input int n);
        int k;
        for (k = 0; k < n; k++) begin
            check_busy(name, 1'b1, busy);
            next_cycle();
        end
        check_busy(name, 1'b0, busy);
        k = 0;
        while (busy && k < 16) begin
            next_cycle();
            k++;
        end
        if (busy) begin
            errors++;
            $display("%s: busy never went low after the command", name);
        end
    endtask

    task automatic run_command(input logic [COL_BITS-1:0] cx, input logic cflip,
                               input obj_row_t cpix);
        logic [ATTR_BITS-1:0] cattr;
        cattr = ATTR_BITS'($urandom);
        apply_command(cx, cattr, cflip, cpix);
        drive_start(cx, cattr, cflip, cpix);
        expect_busy_run({cur_test, " busy"}, SPRITE_PIXELS);
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_done++;
        $display("test %0d %-14s %s, %0d errors", tests_done, cur_test,
                 (errors == test_errors) ? "ok" : "failed", errors - test_errors);
    endtask

    // ########################################################################
    // Test sequence
    // ########################################################################

    initial begin : stimulus
        obj_row_t            pix_a;
        logic [COL_BITS-1:0] xa;
        void'($urandom(SEED));
        {start, x, attr, hflip, pixels, clear, palettemode} = '0;
        row         = '0;
        rcol        = '0;
        rst_n       = 1'b0;
        sweep_go    = 1'b0;
        errors      = 0;
        checks      = 0;
        tests_done  = 0;
        for (int i = 0; i < LINE_WIDTH; i++) begin
            ref_buf[0][i] = '0;
            ref_buf[1][i] = '0;
        end
        repeat (3) @(posedge clock);
        #DRIVE_DLY rst_n = 1'b1;

        begin_test("reset_clear");
        set_row(0);
        sweep_line();
        set_row(1);
        sweep_line();
        run_command(COL_BITS'($urandom % 233), 1'b0, random_row());
        set_row(2);
        sweep_line();
        set_row(3);
        clear_line();
        set_row(4);
        sweep_line();
        end_test();

        begin_test("single_sprite");
        xa = COL_BITS'($urandom % 233);
        set_row(6);
        clear_line();
        run_command(xa, 1'b0, random_row());
        set_row(7);
        sweep_line();
        set_row(8);
        clear_line();
        run_command(xa, 1'b1, random_row());
        set_row(9);
        sweep_line();
        set_row(10);
        clear_line();
        // Partly past the visible line, then wrapping past 255
        run_command(8'd236, 1'b1, random_row());
        run_command(8'd252, 1'b0, random_row());
        set_row(11);
        sweep_line();
        end_test();

        begin_test("priority");
        set_row(12);
        clear_line();
        pix_a    = random_row();
        pix_a[2] = '0;
        pix_a[5] = '0;
        run_command(8'd100, 1'b0, pix_a);
        run_command(8'd104, 1'b0, random_row());
        run_command(8'd98, 1'b1, random_row());
        set_row(13);
        sweep_line();
        end_test();

        begin_test("transparency");
        set_row(14);
        clear_line();
        run_command(8'd40, 1'b0, high_byte_row());
        run_command(8'd44, 1'b0, random_row());
        set_mode(1'b1);
        run_command(8'd46, 1'b1, random_row());
        run_command(8'd60, 1'b0, high_byte_row());
        run_command(8'd62, 1'b0, random_row());
        set_mode(1'b0);
        set_row(15);
        sweep_line();
        end_test();

        begin_test("double_buffer");
        set_row(16);
        clear_line();
        run_command(8'd20, 1'b0, random_row());
        set_row(17);
        clear_line();
        run_command(8'd20, 1'b1, random_row());
        sweep_line();
        set_row(18);
        sweep_line();
        clear_line();
        sweep_line();
        set_row(19);
        sweep_line();
        end_test();

        begin_test("busy_timing");
        set_row(20);
        clear_line();
        run_command(8'd150, 1'b0, random_row());
        pix_a = random_row();
        apply_command(8'd120, 4'hb, 1'b0, pix_a);
        drive_start(8'd120, 4'hb, 1'b0, pix_a);
        check_busy("busy_timing accept", 1'b1, busy);
        // Second start lands mid-command and has to be dropped
        drive_start(8'd200, 4'h6, 1'b0, random_row());
        expect_busy_run("busy_timing overlap", SPRITE_PIXELS - 2);
        set_row(21);
        sweep_line();
        // A clear during a command only lands once all its pixels are written
        pix_a = random_row();
        apply_command(8'd30, 4'h3, 1'b0, pix_a);
        drive_start(8'd30, 4'h3, 1'b0, pix_a);
        clear_line();
        expect_busy_run("busy_timing clear", SPRITE_PIXELS - 2);
        set_row(22);
        sweep_line();
        end_test();

        $display("tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_obj_line_engine

//--- verilog/obj_line_engine.sv
module obj_line_engine (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [obj_pkg::COL_BITS-1:0]  x,
    input  logic [obj_pkg::ATTR_BITS-1:0] attr,
    input  logic                          hflip,
    input  obj_pkg::obj_row_t             pixels,
    input  logic                          palettemode,
    input  logic                          clear,
    input  logic [obj_pkg::COL_BITS-1:0]  row,
    input  logic [obj_pkg::COL_BITS-1:0]  rcol,
    output logic                          busy,
    output obj_pkg::obj_pixel_t           rdata
);

    obj_write_if wr_bus ();

    obj_line_renderer renderer (
        .clock  (clock),
        .rst_n  (rst_n),
        .start  (start),
        .x      (x),
        .attr   (attr),
        .hflip  (hflip),
        .pixels (pixels),
        .clear  (clear),
        .busy   (busy),
        .wr     (wr_bus.source)
    );

    // Only the row parity matters to the buffer pair
    obj_row_double_buffer row_store (
        .clock       (clock),
        .rst_n       (rst_n),
        .row_odd     (row[0]),
        .palettemode (palettemode),
        .wr          (wr_bus.sink),
        .rcol        (rcol),
        .rdata       (rdata)
    );

endmodule : obj_line_engine

//--- verilog/obj_line_renderer.sv
module obj_line_renderer (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [obj_pkg::COL_BITS-1:0]  x,
    input  logic [obj_pkg::ATTR_BITS-1:0] attr,
    input  logic                          hflip,
    input  obj_pkg::obj_row_t             pixels,
    input  logic                          clear,
    output logic                          busy,
    obj_write_if.source                   wr
);
    import obj_pkg::*;

    logic                  busy_q;
    logic [SLOT_BITS-1:0]  slot_q;
    logic                  clear_pend_q;
    logic                  accept;
    logic                  last_slot;

    // Command fields captured on an accepted start
    logic [COL_BITS-1:0]   x_q;
    logic [ATTR_BITS-1:0]  attr_q;
    logic                  hflip_q;
    obj_row_t              pixels_q;

    logic [COL_BITS:0]     col_sum;
    logic                  col_ok;
    logic [SLOT_BITS-1:0]  pix_idx;
    logic [COLOR_BITS-1:0] pix_color;

    assign accept    = start & ~busy_q;
    assign last_slot = (slot_q == SLOT_BITS'(SPRITE_PIXELS - 1));
    assign busy      = busy_q;

    // ########################################################################
    // Slot sequencer
    // ########################################################################

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            slot_q <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            slot_q <= '0;
        end else if (busy_q) begin
            slot_q <= slot_q + 1'b1;
            if (last_slot) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            x_q      <= x;
            attr_q   <= attr;
            hflip_q  <= hflip;
            pixels_q <= pixels;
        end
    end

    // Clear requests that arrive mid-command wait for the sequencer to go idle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            clear_pend_q <= 1'b0;
        end else if (busy_q) begin
            clear_pend_q <= clear_pend_q | clear;
        end else begin
            clear_pend_q <= 1'b0;
        end
    end

    // ########################################################################
    // Write port
    // ########################################################################

    // One extra bit catches columns that wrap past 255
    assign col_sum = {1'b0, x_q} + (COL_BITS + 1)'(slot_q);
    assign col_ok  = (col_sum < (COL_BITS + 1)'(LINE_WIDTH));

    // Flipping walks the pixels from the far end
    assign pix_idx   = slot_q ^ {SLOT_BITS{hflip_q}};
    assign pix_color = pixels_q[pix_idx];

    assign wr.we           = busy_q & col_ok;
    assign wr.wcol         = col_sum[COL_BITS-1:0];
    assign wr.wdata.prio   = attr_q[3:2];
    assign wr.wdata.semi   = attr_q[1];
    assign wr.wdata.window = attr_q[0];
    assign wr.wdata.color  = pix_color;
    assign wr.clear        = ~busy_q & (clear | clear_pend_q);

endmodule : obj_line_renderer

//--- verilog/obj_pkg.sv
package obj_pkg;

    // ########################################################################
    // Line and command geometry
    // ########################################################################

    // Visible columns on one video line
    localparam int LINE_WIDTH = 240;
    localparam int COL_BITS = 8;

    localparam int COLOR_BITS = 16;
    localparam int ATTR_BITS = 4;

    // One sprite row command always carries this many pixels
    localparam int SPRITE_PIXELS = 8;
    localparam int SLOT_BITS = $clog2(SPRITE_PIXELS);

    // ########################################################################
    // Pixel layout
    // ########################################################################

    // Attribute field sits above the colour, so the stored pixel is 20 bits
    typedef struct packed {
        logic [1:0]            prio;
        logic                  semi;
        logic                  window;
        logic [COLOR_BITS-1:0] color;
    } obj_pixel_t;

    // Pixel 0 lives in the low 16 bits
    typedef logic [SPRITE_PIXELS-1:0][COLOR_BITS-1:0] obj_row_t;

endpackage : obj_pkg

//--- verilog/obj_row_buffer.sv
module obj_row_buffer (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         en,
    input  logic                         palettemode,
    obj_write_if.sink                    wr,
    input  logic [obj_pkg::COL_BITS-1:0] rcol,
    output obj_pkg::obj_pixel_t          rdata
);
    import obj_pkg::*;

    obj_pixel_t            cols [LINE_WIDTH];
    logic [LINE_WIDTH-1:0] col_sel;
    logic [LINE_WIDTH-1:0] col_open;
    logic                  do_clear;
    logic                  do_write;

    // Palette indices only use the low byte, so that byte alone decides
    function automatic logic is_transparent(input obj_pixel_t pix, input logic pal);
        logic result;
        if (pal) begin
            result = (pix.color[7:0] == 8'd0);
        end else begin
            result = (pix.color == '0);
        end
        return result;
    endfunction

    assign do_clear = en & wr.clear;
    assign do_write = en & wr.we;

    // ########################################################################
    // Column storage
    // ########################################################################

    for (genvar i = 0; i < LINE_WIDTH; i++) begin : g_col
        assign col_sel[i] = (wr.wcol == COL_BITS'(i));

        // A column stays open until something opaque lands in it
        assign col_open[i] = is_transparent(cols[i], palettemode);

        always_ff @(posedge clock or negedge rst_n) begin
            if (!rst_n) begin
                cols[i] <= '0;
            end else if (do_clear) begin
                cols[i] <= '0;
            end else if (do_write && col_sel[i] && col_open[i]) begin
                cols[i] <= wr.wdata;
            end
        end
    end

    // ########################################################################
    // Read port
    // ########################################################################

    // Columns past the visible line read back as zero
    always_comb begin
        rdata = '0;
        if (rcol < COL_BITS'(LINE_WIDTH)) begin
            rdata = cols[rcol];
        end
    end

endmodule : obj_row_buffer

//--- verilog/obj_row_double_buffer.sv
module obj_row_double_buffer (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         row_odd,
    input  logic                         palettemode,
    obj_write_if.sink                    wr,
    input  logic [obj_pkg::COL_BITS-1:0] rcol,
    output obj_pkg::obj_pixel_t          rdata
);
    import obj_pkg::*;

    obj_pixel_t rdata_even;
    obj_pixel_t rdata_odd;
    logic       en_even;
    logic       en_odd;

    // The half matching the row parity takes writes and clears
    assign en_even = ~row_odd;
    assign en_odd  = row_odd;

    obj_row_buffer even (
        .clock       (clock),
        .rst_n       (rst_n),
        .en          (en_even),
        .palettemode (palettemode),
        .wr          (wr),
        .rcol        (rcol),
        .rdata       (rdata_even)
    );

    obj_row_buffer odd (
        .clock       (clock),
        .rst_n       (rst_n),
        .en          (en_odd),
        .palettemode (palettemode),
        .wr          (wr),
        .rcol        (rcol),
        .rdata       (rdata_odd)
    );

    // Display reads the line that was built during the previous row
    assign rdata = row_odd ? rdata_even : rdata_odd;

endmodule : obj_row_double_buffer

//--- verilog/obj_write_if.sv
interface obj_write_if;
    import obj_pkg::*;

    obj_pixel_t            wdata;
    logic [COL_BITS-1:0]   wcol;
    logic                  we;
    logic                  clear;

    // Renderer side owns both writes and clears
    modport source (
        output wdata,
        output wcol,
        output we,
        output clear
    );

    modport sink (
        input  wdata,
        input  wcol,
        input  we,
        input  clear
    );

endinterface : obj_write_if
